// File: verilog/demux_pkg.sv
// read demux sizes, port select and id types, AR/R channel structs
package demux_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned SEL_WIDTH  = $clog2(NUM_PORTS);
  localparam int unsigned ID_WIDTH   = 4;
  // low id bits that pick the tracker counter
  localparam int unsigned LOOK_BITS  = 2;
  localparam int unsigned NUM_GROUPS = 2 ** LOOK_BITS;
  // counter at all ones is full
  localparam int unsigned CNT_WIDTH  = 3;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  // burst length minus one, 1 to 16 beats
  localparam int unsigned LEN_WIDTH  = 4;

  // --------------------------------------------------
  // scalar types
  // --------------------------------------------------
  typedef logic [SEL_WIDTH-1:0] sel_t;
  typedef logic [ID_WIDTH-1:0]  id_t;
  typedef logic [LOOK_BITS-1:0] group_t;

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  // read address, 40 bits
  typedef struct packed {
    id_t                   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_chan_t;

  // AR plus its target port, 42 bits
  typedef struct packed {
    ar_chan_t ar;
    sel_t     sel;
  } ar_req_t;

  // read data beat, 37 bits
  typedef struct packed {
    id_t                   id;
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } r_chan_t;

endpackage

// File: verilog/id_track_if.sv
// id_track_if: lookup, full and push signals between AR router and id tracker
`timescale 1ns/1ps

interface id_track_if;

  // lookup of the group at the head of the AR spill register
  demux_pkg::group_t lookup_group;
  demux_pkg::sel_t   lookup_sel;
  logic              lookup_busy;
  // some counter has no room left
  logic              full;

  // one-cycle strobe on a downstream AR handshake
  logic              push;
  demux_pkg::group_t push_group;
  demux_pkg::sel_t   push_sel;

  modport router (
    output lookup_group, push, push_group, push_sel,
    input  lookup_sel, lookup_busy, full
  );

  modport tracker (
    input  lookup_group, push, push_group, push_sel,
    output lookup_sel, lookup_busy, full
  );

endinterface

// File: verilog/spill_reg.sv
// spill_reg: two-entry valid/ready buffer, payload set by a type parameter
`timescale 1ns/1ps

module spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // slot a takes new input, slot b holds a beat the sink refused
  logic     a_full_q, b_full_q;
  payload_t a_data_q, b_data_q;
  logic     a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // b is always the older entry
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// File: verilog/id_tracker.sv
// id_tracker: per id group in-flight counters and bound port selects
`timescale 1ns/1ps

module id_tracker (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // last beat of a read left through the R spill register
  input  logic               pop_i,
  input  demux_pkg::group_t  pop_group_i,
  id_track_if.tracker        trk
);

  logic [demux_pkg::CNT_WIDTH-1:0] cnt_q [demux_pkg::NUM_GROUPS];
  demux_pkg::sel_t                 sel_q [demux_pkg::NUM_GROUPS];
  logic [demux_pkg::NUM_GROUPS-1:0] busy;
  logic [demux_pkg::NUM_GROUPS-1:0] cnt_full;

  // --------------------------------------------------
  // one counter per group
  // --------------------------------------------------
  for (genvar g = 0; g < demux_pkg::NUM_GROUPS; g++) begin : gen_group
    logic push_hit;
    logic pop_hit;

    assign push_hit = trk.push && (trk.push_group == demux_pkg::group_t'(g));
    assign pop_hit  = pop_i && (pop_group_i == demux_pkg::group_t'(g));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[g] <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q[g] <= cnt_q[g] + 1'b1;
      end else if (pop_hit && !push_hit) begin
        cnt_q[g] <= cnt_q[g] - 1'b1;
      end
    end

    // a push always targets the bound port or an idle group
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        sel_q[g] <= '0;
      end else if (push_hit) begin
        sel_q[g] <= trk.push_sel;
      end
    end

    assign busy[g]     = |cnt_q[g];
    assign cnt_full[g] = &cnt_q[g];
  end

  // --------------------------------------------------
  // lookup and full flag
  // --------------------------------------------------
  // same cycle as the request at the spill head
  assign trk.lookup_busy = busy[trk.lookup_group];
  assign trk.lookup_sel  = sel_q[trk.lookup_group];

  // stall on any full counter, not only the looked-up one
  assign trk.full = |cnt_full;

endmodule

// File: verilog/ar_router.sv
// ar_router: AR eligibility check against the tracker and routing to one port
`timescale 1ns/1ps

module ar_router (
  // head of the AR spill register
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  demux_pkg::ar_req_t                  req_i,
  // downstream ports, payload shared by all
  output demux_pkg::ar_chan_t                 mst_ar_o,
  output logic [demux_pkg::NUM_PORTS-1:0]     mst_ar_valid_o,
  input  logic [demux_pkg::NUM_PORTS-1:0]     mst_ar_ready_i,
  id_track_if.router                          trk
);

  demux_pkg::group_t req_group;
  logic              eligible;
  logic              ar_valid;
  logic              ar_ready;

  assign req_group = req_i.ar.id[demux_pkg::LOOK_BITS-1:0];

  // --------------------------------------------------
  // eligibility
  // --------------------------------------------------
  assign trk.lookup_group = req_group;

  // group idle, or its reads already go to this same port
  assign eligible = !trk.full &&
                    (!trk.lookup_busy || (trk.lookup_sel == req_i.sel));

  // once eligible, the head stays eligible: only pops change
  // the tracker while it waits, and pops never block a request
  assign ar_valid = req_valid_i && eligible;
  assign ar_ready = ar_valid && mst_ar_ready_i[req_i.sel];

  // --------------------------------------------------
  // port decode
  // --------------------------------------------------
  always_comb begin
    mst_ar_valid_o = '0;
    for (int unsigned p = 0; p < demux_pkg::NUM_PORTS; p++) begin
      if (ar_valid && (req_i.sel == demux_pkg::sel_t'(p))) begin
        mst_ar_valid_o[p] = 1'b1;
      end
    end
  end

  assign mst_ar_o = req_i.ar;

  // --------------------------------------------------
  // completion
  // --------------------------------------------------
  // pop the spill head and count the read in one step
  assign req_ready_o    = ar_ready;
  assign trk.push       = ar_ready;
  assign trk.push_group = req_group;
  assign trk.push_sel   = req_i.sel;

endmodule

// File: verilog/r_arbiter.sv
// r_arbiter: round-robin merge of port R channels, tracker pop on last beats
`timescale 1ns/1ps

module r_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  // downstream port R channels
  input  demux_pkg::r_chan_t [demux_pkg::NUM_PORTS-1:0]    mst_r_i,
  input  logic [demux_pkg::NUM_PORTS-1:0]                  mst_r_valid_i,
  output logic [demux_pkg::NUM_PORTS-1:0]                  mst_r_ready_o,
  // merged beat towards the R spill register
  output demux_pkg::r_chan_t                               out_o,
  output logic                                             out_valid_o,
  input  logic                                             out_ready_i,
  // tracker pop
  output logic                                             pop_o,
  output demux_pkg::group_t                                pop_group_o
);

  demux_pkg::sel_t prio_q;
  demux_pkg::sel_t gnt_q;
  logic            lock_q;
  demux_pkg::sel_t gnt_idx;
  logic            handshake;

  // --------------------------------------------------
  // grant selection
  // --------------------------------------------------
  always_comb begin : grant_search
    demux_pkg::sel_t cand;
    logic            found;
    found   = 1'b0;
    gnt_idx = prio_q;
    // first valid port at or after the priority pointer
    for (int unsigned i = 0; i < demux_pkg::NUM_PORTS; i++) begin
      cand = demux_pkg::sel_t'((int'(prio_q) + i) % demux_pkg::NUM_PORTS);
      if (!found && mst_r_valid_i[cand]) begin
        found   = 1'b1;
        gnt_idx = cand;
      end
    end
    // stalled beat keeps its grant
    if (lock_q) begin
      gnt_idx = gnt_q;
    end
  end

  assign out_valid_o = mst_r_valid_i[gnt_idx];
  assign out_o       = mst_r_i[gnt_idx];
  assign handshake   = out_valid_o && out_ready_i;

  always_comb begin
    mst_r_ready_o          = '0;
    mst_r_ready_o[gnt_idx] = handshake;
  end

  // --------------------------------------------------
  // lock and pointer state
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
      gnt_q  <= '0;
      prio_q <= '0;
    end else begin
      lock_q <= out_valid_o && !out_ready_i;
      gnt_q  <= gnt_idx;
      if (handshake) begin
        // served port drops to lowest priority
        prio_q <= demux_pkg::sel_t'((int'(gnt_idx) + 1) % demux_pkg::NUM_PORTS);
      end
    end
  end

  // read retires when its last beat enters the output spill
  assign pop_o       = handshake && out_o.last;
  assign pop_group_o = out_o.id[demux_pkg::LOOK_BITS-1:0];

endmodule

// File: verilog/read_demux.sv
// read_demux: top level of the AR/R demux with spills, router, tracker, arbiter
`timescale 1ns/1ps

module read_demux (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // upstream AR
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  input  demux_pkg::ar_chan_t                           ar_i,
  input  demux_pkg::sel_t                               ar_select_i,
  // downstream AR
  output demux_pkg::ar_chan_t                           mst_ar_o,
  output logic [demux_pkg::NUM_PORTS-1:0]               mst_ar_valid_o,
  input  logic [demux_pkg::NUM_PORTS-1:0]               mst_ar_ready_i,
  // downstream R
  input  demux_pkg::r_chan_t [demux_pkg::NUM_PORTS-1:0] mst_r_i,
  input  logic [demux_pkg::NUM_PORTS-1:0]               mst_r_valid_i,
  output logic [demux_pkg::NUM_PORTS-1:0]               mst_r_ready_o,
  // upstream R
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  output demux_pkg::r_chan_t                            r_o
);

  demux_pkg::ar_req_t ar_req_in, ar_req_head;
  logic               ar_head_valid, ar_head_ready;
  demux_pkg::r_chan_t r_merged;
  logic               r_merged_valid, r_merged_ready;
  logic               pop;
  demux_pkg::group_t  pop_group;

  id_track_if trk_if ();

  // --------------------------------------------------
  // AR path
  // --------------------------------------------------
  // select travels with the request through the spill
  assign ar_req_in.ar  = ar_i;
  assign ar_req_in.sel = ar_select_i;

  spill_reg #(
    .payload_t ( demux_pkg::ar_req_t )
  ) i_ar_spill (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .valid_i ( ar_valid_i    ),
    .ready_o ( ar_ready_o    ),
    .data_i  ( ar_req_in     ),
    .valid_o ( ar_head_valid ),
    .ready_i ( ar_head_ready ),
    .data_o  ( ar_req_head   )
  );

  ar_router i_ar_router (
    .req_valid_i    ( ar_head_valid  ),
    .req_ready_o    ( ar_head_ready  ),
    .req_i          ( ar_req_head    ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .trk            ( trk_if.router  )
  );

  id_tracker i_id_tracker (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .pop_i       ( pop            ),
    .pop_group_i ( pop_group      ),
    .trk         ( trk_if.tracker )
  );

  // --------------------------------------------------
  // R path
  // --------------------------------------------------
  r_arbiter i_r_arbiter (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .mst_r_i       ( mst_r_i        ),
    .mst_r_valid_i ( mst_r_valid_i  ),
    .mst_r_ready_o ( mst_r_ready_o  ),
    .out_o         ( r_merged       ),
    .out_valid_o   ( r_merged_valid ),
    .out_ready_i   ( r_merged_ready ),
    .pop_o         ( pop            ),
    .pop_group_o   ( pop_group      )
  );

  spill_reg #(
    .payload_t ( demux_pkg::r_chan_t )
  ) i_r_spill (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( r_merged_valid ),
    .ready_o ( r_merged_ready ),
    .data_i  ( r_merged       ),
    .valid_o ( r_valid_o      ),
    .ready_i ( r_ready_i      ),
    .data_o  ( r_o            )
  );

endmodule

// File: tests/read_demux_props.sv
// read_demux_props: assertions on router and arbiter handshakes, one-hot AR valid
`timescale 1ns/1ps

module read_demux_props (
  input logic                              clk_i,
  input logic                              rst_n_i,
  // router side of the downstream AR ports
  input demux_pkg::ar_chan_t               ar_chan_i,
  input logic [demux_pkg::NUM_PORTS-1:0]   ar_valid_i,
  input logic [demux_pkg::NUM_PORTS-1:0]   ar_ready_i,
  // arbiter output towards the R spill register
  input demux_pkg::r_chan_t                r_chan_i,
  input logic                              r_valid_i,
  input logic                              r_ready_i
);

  logic ar_stalled;

  assign ar_stalled = |(ar_valid_i & ~ar_ready_i);

  ar_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_stalled |=> (ar_valid_i == $past(ar_valid_i)))
    else $error("AR valid changed before its handshake");

  ar_payload_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_stalled |=> (ar_chan_i == $past(ar_chan_i)))
    else $error("AR payload changed before its handshake");

  ar_one_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ar_valid_i))
    else $error("AR valid raised at more than one port");

  r_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_i && !r_ready_i) |=> (r_valid_i && r_chan_i == $past(r_chan_i)))
    else $error("merged R beat dropped or changed while stalled");

endmodule

bind read_demux read_demux_props i_read_demux_props (
  .clk_i      ( clk_i          ),
  .rst_n_i    ( rst_n_i        ),
  .ar_chan_i  ( mst_ar_o       ),
  .ar_valid_i ( mst_ar_valid_o ),
  .ar_ready_i ( mst_ar_ready_i ),
  .r_chan_i   ( r_merged       ),
  .r_valid_i  ( r_merged_valid ),
  .r_ready_i  ( r_merged_ready )
);

// File: tests/tb_read_demux.sv
// clock, reset, LFSR stimulus, port responders, scoreboard and watchdog for the read demux
`timescale 1ns/1ps

module tb_read_demux;

  localparam int CLK_PERIOD     = 8;
  localparam int PORTS          = demux_pkg::NUM_PORTS;
  localparam int GROUPS         = demux_pkg::NUM_GROUPS;
  localparam int REQS_PER_PHASE = 60;
  localparam int NUM_PHASES     = 4;
  localparam int TOTAL_REQS     = NUM_PHASES * REQS_PER_PHASE;
  localparam int MAX_BEATS      = 16;
  localparam int MAX_LAT        = 7;
  localparam int WATCHDOG_NS    = TOTAL_REQS * MAX_BEATS * (MAX_LAT + 1) * CLK_PERIOD * 2;
  // phases of the run
  localparam int PH_RANDOM      = 0;
  localparam int PH_GROUPS      = 1;
  localparam int PH_BACKPRESS   = 2;
  localparam int PH_FAIR        = 3;

  logic                                          clk_i;
  logic                                          rst_n_i;
  logic                                          ar_valid_i;
  logic                                          ar_ready_o;
  demux_pkg::ar_chan_t                           ar_i;
  demux_pkg::sel_t                               ar_select_i;
  demux_pkg::ar_chan_t                           mst_ar_o;
  logic [PORTS-1:0]                              mst_ar_valid_o;
  logic [PORTS-1:0]                              mst_ar_ready_i;
  demux_pkg::r_chan_t [PORTS-1:0]                mst_r_i;
  logic [PORTS-1:0]                              mst_r_valid_i;
  logic [PORTS-1:0]                              mst_r_ready_o;
  logic                                          r_valid_o;
  logic                                          r_ready_i;
  demux_pkg::r_chan_t                            r_o;

  // --------------------------------------------------
  // scoreboard and model state
  // --------------------------------------------------
  logic [31:0]         lfsr_q;
  int                  phase;
  int                  launched;
  logic                ar_hs_q;
  logic [PORTS-1:0]    r_hs_q;
  demux_pkg::ar_chan_t exp_ar_q [$];
  demux_pkg::sel_t     exp_sel_q [$];
  demux_pkg::r_chan_t  exp_r_q [$];
  // accepted reads waiting at each responder
  demux_pkg::ar_chan_t rsp_q [PORTS][$];
  int                  beat_idx [PORTS];
  int                  gap_cnt [PORTS];
  int                  wait_cnt [PORTS];
  // reads in flight per id group and port
  int                  out_cnt [GROUPS][PORTS];

  read_demux i_read_demux (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ar_valid_i     ( ar_valid_i     ),
    .ar_ready_o     ( ar_ready_o     ),
    .ar_i           ( ar_i           ),
    .ar_select_i    ( ar_select_i    ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  ),
    .r_valid_o      ( r_valid_o      ),
    .r_ready_i      ( r_ready_i      ),
    .r_o            ( r_o            )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("watchdog expired before all reads completed");
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] beat_data(input logic [31:0] addr, input int beat);
    return addr ^ (32'(beat) * 32'h0100_0193);
  endfunction

  // back-pressure phase flips the ready rarely for long stretches
  function automatic logic pick_ready(input logic cur);
    if (phase == PH_BACKPRESS) begin
      return (rand_bits(3) == 0) ? !cur : cur;
    end
    if (phase == PH_FAIR) begin
      return 1'b1;
    end
    return rand_bits(2) != 0;
  endfunction

  function automatic int pick_gap();
    if (phase == PH_FAIR) begin
      return 0;
    end
    return (phase == PH_BACKPRESS) ? int'(rand_bits(3)) : int'(rand_bits(2));
  endfunction

  function automatic bit drained(input int n);
    bit empty;
    empty = (launched == n) && !ar_valid_i && (exp_ar_q.size() == 0) && (exp_r_q.size() == 0);
    for (int p = 0; p < PORTS; p++) begin
      if (rsp_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic check_ar(input string test, input demux_pkg::ar_chan_t exp_ar,
                          input demux_pkg::sel_t exp_sel, input demux_pkg::ar_chan_t act_ar,
                          input demux_pkg::sel_t act_sel);
    if (exp_ar !== act_ar || exp_sel !== act_sel) begin
      stop_on_error($sformatf("Fail %s: expected %h at port %0d, actual %h at port %0d",
                              test, exp_ar, exp_sel, act_ar, act_sel));
    end
  endtask

  task automatic check_r(input string test, input demux_pkg::r_chan_t exp_r,
                         input demux_pkg::r_chan_t act_r);
    if (exp_r !== act_r) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", test, exp_r, act_r));
    end
  endtask

  // --------------------------------------------------
  // monitor sampled at the falling edge
  // --------------------------------------------------
  task automatic monitor();
    int g;
    ar_hs_q = ar_valid_i && ar_ready_o;
    if (ar_hs_q) begin
      exp_ar_q.push_back(ar_i);
      exp_sel_q.push_back(ar_select_i);
    end
    if ($countones(mst_ar_valid_o) > 1) begin
      stop_on_error("more than one port sees the same AR request");
    end
    // group check uses counts from before this cycle's handshakes
    for (int p = 0; p < PORTS; p++) begin
      g = int'(mst_ar_o.id[demux_pkg::LOOK_BITS-1:0]);
      for (int q = 0; q < PORTS; q++) begin
        if (mst_ar_valid_o[p] && q != p && out_cnt[g][q] != 0) begin
          stop_on_error($sformatf("AR of group %0d shown at port %0d while port %0d busy",
                                  g, p, q));
        end
      end
    end
    for (int p = 0; p < PORTS; p++) begin
      if (mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
        if (exp_ar_q.size() == 0) begin
          stop_on_error("AR appeared at a port without an upstream request");
        end
        check_ar("routing", exp_ar_q.pop_front(), exp_sel_q.pop_front(), mst_ar_o,
                 demux_pkg::sel_t'(p));
        rsp_q[p].push_back(mst_ar_o);
        out_cnt[int'(mst_ar_o.id[demux_pkg::LOOK_BITS-1:0])][p]++;
      end
    end
    if ((mst_r_ready_o & ~mst_r_valid_i) != '0) begin
      stop_on_error("R ready raised at a port with no valid beat");
    end
    r_hs_q = mst_r_valid_i & mst_r_ready_o;
    for (int p = 0; p < PORTS; p++) begin
      if (r_hs_q[p]) begin
        exp_r_q.push_back(mst_r_i[p]);
        // tracker retires the read when its last beat leaves the port
        if (mst_r_i[p].last) begin
          out_cnt[int'(mst_r_i[p].id[demux_pkg::LOOK_BITS-1:0])][p]--;
        end
      end
      if (r_hs_q[p] || !mst_r_valid_i[p]) begin
        wait_cnt[p] = 0;
      end else if (r_hs_q != '0) begin
        wait_cnt[p]++;
        if (wait_cnt[p] > PORTS - 1) begin
          stop_on_error($sformatf("port %0d skipped by more than %0d grants", p, PORTS - 1));
        end
      end
    end
    if (r_valid_o && r_ready_i) begin
      if (exp_r_q.size() == 0) begin
        stop_on_error("R beat appeared upstream that no port produced");
      end
      check_r("return", exp_r_q.pop_front(), r_o);
    end
  endtask

  // --------------------------------------------------
  // driver 1 ns after the rising edge
  // --------------------------------------------------
  task automatic drive(input int n);
    if (!ar_valid_i || ar_hs_q) begin
      ar_valid_i = 1'b0;
      if (launched < n && (phase == PH_FAIR || rand_bits(2) != 0)) begin
        ar_valid_i  = 1'b1;
        launched++;
        ar_i.id     = demux_pkg::id_t'(rand_bits(demux_pkg::ID_WIDTH));
        // only groups 0 and 1 spread over all ports
        if (phase == PH_GROUPS) begin
          ar_i.id[1] = 1'b0;
        end
        ar_i.addr   = rand_bits(32);
        ar_i.len    = (phase == PH_FAIR) ? 4'hf : 4'(rand_bits(4));
        ar_select_i = demux_pkg::sel_t'(rand_bits(demux_pkg::SEL_WIDTH));
      end
    end
    for (int p = 0; p < PORTS; p++) begin
      mst_ar_ready_i[p] = pick_ready(mst_ar_ready_i[p]);
      if (r_hs_q[p]) begin
        if (mst_r_i[p].last) begin
          void'(rsp_q[p].pop_front());
          beat_idx[p] = 0;
        end else begin
          beat_idx[p]++;
        end
        gap_cnt[p] = pick_gap();
      end
      if (!mst_r_valid_i[p] || r_hs_q[p]) begin
        mst_r_valid_i[p] = 1'b0;
        if (rsp_q[p].size() != 0 && gap_cnt[p] != 0) begin
          gap_cnt[p]--;
        end else if (rsp_q[p].size() != 0) begin
          mst_r_valid_i[p]   = 1'b1;
          mst_r_i[p].id      = rsp_q[p][0].id;
          mst_r_i[p].data    = beat_data(rsp_q[p][0].addr, beat_idx[p]);
          mst_r_i[p].last    = (beat_idx[p] == int'(rsp_q[p][0].len));
        end
      end
    end
    r_ready_i = pick_ready(r_ready_i);
  endtask

  task automatic run_phase(input int ph, input int n);
    phase    = ph;
    launched = 0;
    do begin
      @(negedge clk_i);
      monitor();
      @(posedge clk_i);
      #1;
      drive(n);
    end while (!drained(n));
  endtask

  // nothing may stay pending once every read has completed
  function automatic bit outputs_idle();
    return ar_ready_o && !r_valid_o && (mst_ar_valid_o == '0) && (mst_r_ready_o == '0);
  endfunction

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    lfsr_q         = 32'ha2b1;
    phase          = PH_RANDOM;
    launched       = 0;
    ar_hs_q        = 1'b0;
    r_hs_q         = '0;
    rst_n_i        = 1'b0;
    ar_valid_i     = 1'b0;
    ar_i           = '0;
    ar_select_i    = '0;
    mst_ar_ready_i = '0;
    mst_r_i        = '0;
    mst_r_valid_i  = '0;
    r_ready_i      = 1'b0;
    for (int p = 0; p < PORTS; p++) begin
      beat_idx[p] = 0;
      gap_cnt[p]  = 0;
      wait_cnt[p] = 0;
      for (int g = 0; g < GROUPS; g++) begin
        out_cnt[g][p] = 0;
      end
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // idle outputs until the first request arrives
    repeat (3) begin
      @(negedge clk_i);
      if (r_valid_o || mst_ar_valid_o != '0 || mst_r_ready_o != '0) begin
        stop_on_error("outputs became active after reset without any stimulus");
      end
    end
    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      run_phase(ph, REQS_PER_PHASE);
    end
    @(negedge clk_i);
    if (outputs_idle()) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_error("DUT still shows a request or beat after all reads completed");
    end
  end

endmodule

// File: tb.f
verilog/demux_pkg.sv
verilog/id_track_if.sv
verilog/spill_reg.sv
verilog/id_tracker.sv
verilog/ar_router.sv
verilog/r_arbiter.sv
verilog/read_demux.sv
tests/read_demux_props.sv
tests/tb_read_demux.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_read_demux \
  -f tb.f -o tb_read_demux \
  && ./obj_dir/tb_read_demux | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
